// File: list.f
hdl/icache_pkg.sv
hdl/icache_tag_ram.sv
hdl/icache_data_ram.sv
hdl/icache_lookup.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
dv/icache_properties.sv
dv/icache_tb.sv

// File: Makefile
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: dv/icache_tb.sv
// Directed testbench for the cache with SETS fixed at 16; memory answers each request in 1 to 4 cycles
`default_nettype none

module icache_tb;

  localparam int SETS           = 16;
  localparam int IDX_W          = $clog2(SETS);
  localparam int TAG_W          = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - IDX_W;
  localparam int NUM_RANDOM     = 200;
  // Roughly 225 fetches and one flush, each far below 80 cycles
  localparam int TIMEOUT_CYCLES = 20000;
  localparam logic [31:0] WORD_XOR = 32'h5a5a0000;

  logic                              clk;
  logic                              rst_n;
  logic                              fetch_req_i;
  logic [icache_pkg::ADDR_W-1:0]     fetch_addr_i;
  logic                              fetch_ack_o;
  logic [icache_pkg::WORD_W-1:0]     fetch_data_o;
  logic                              flush_req_i;
  logic                              flush_ack_o;
  logic                              mem_req_o;
  logic [icache_pkg::ADDR_W-1:0]     mem_addr_o;
  logic                              mem_ack_i;
  logic [icache_pkg::LINE_W-1:0]     mem_line_i;

  int                                cycles = 0;
  int                                mem_reqs = 0;
  logic [icache_pkg::ADDR_W-1:0]     last_mem_addr;
  logic [31:0]                       addr_seed;

  // Cache content model
  logic [TAG_W-1:0] model_tag [SETS][icache_pkg::WAYS];
  logic             model_valid [SETS][icache_pkg::WAYS];
  int               model_rr;

  icache_top #(
    .SETS (SETS)
  ) i_icache_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_req_i  (fetch_req_i),
    .fetch_addr_i (fetch_addr_i),
    .fetch_ack_o  (fetch_ack_o),
    .fetch_data_o (fetch_data_o),
    .flush_req_i  (flush_req_i),
    .flush_ack_o  (flush_ack_o),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .mem_ack_i    (mem_ack_i),
    .mem_line_i   (mem_line_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [icache_pkg::WORD_W-1:0] expected_word(
    input logic [icache_pkg::ADDR_W-1:0] addr
  );
    return {addr[icache_pkg::ADDR_W-1:2], 2'b00} ^ WORD_XOR;
  endfunction

  function automatic logic [icache_pkg::LINE_W-1:0] make_line(
    input logic [icache_pkg::ADDR_W-1:0] line_addr
  );
    logic [icache_pkg::LINE_W-1:0] data;
    for (int i = 0; i < icache_pkg::LINE_WORDS; i++) begin
      data[i*icache_pkg::WORD_W +: icache_pkg::WORD_W] = expected_word(line_addr + 32'(4 * i));
    end
    return data;
  endfunction

  // Returns 1 on a predicted miss and fills the model like the cache would
  function automatic bit model_access(input logic [icache_pkg::ADDR_W-1:0] addr);
    int               idx;
    int               way;
    logic [TAG_W-1:0] tag;
    idx = int'(addr[icache_pkg::OFFSET_W +: IDX_W]);
    tag = addr[icache_pkg::ADDR_W-1 -: TAG_W];
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      if (model_valid[idx][w] && model_tag[idx][w] == tag) begin
        return 1'b0;
      end
    end
    way = -1;
    for (int w = icache_pkg::WAYS - 1; w >= 0; w--) begin
      if (!model_valid[idx][w]) begin
        way = w;
      end
    end
    if (way < 0) begin
      way      = model_rr;
      model_rr = (model_rr + 1) % icache_pkg::WAYS;
    end
    model_valid[idx][way] = 1'b1;
    model_tag[idx][way]   = tag;
    return 1'b1;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic compare_word(input string name, input logic [icache_pkg::WORD_W-1:0] got,
                              input logic [icache_pkg::WORD_W-1:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic compare_addr(input string name, input logic [icache_pkg::ADDR_W-1:0] got,
                              input logic [icache_pkg::ADDR_W-1:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic compare_miss(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  // Memory model, one line per request after a short random delay
  initial begin
    int          delay;
    logic [31:0] delay_seed;
    mem_ack_i  = 1'b0;
    mem_line_i = '0;
    delay_seed = lcg_step(32'h27b3);
    forever begin
      @(posedge clk);
      if (mem_req_o && !mem_ack_i) begin
        mem_reqs++;
        last_mem_addr = mem_addr_o;
        delay         = 1 + int'(delay_seed[17:16]);
        delay_seed    = lcg_step(delay_seed);
        repeat (delay - 1) @(posedge clk);
        mem_ack_i  <= 1'b1;
        mem_line_i <= make_line(mem_addr_o);
        do begin
          @(posedge clk);
        end while (mem_req_o);
        mem_ack_i <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $fatal(1, "Timeout");
    end else if (i_icache_top.i_icache_properties.fail_count != 0) begin
      $display("A handshake assertion on the cache failed");
      $display("TESTBENCH FAILED");
      $fatal(1, "Assertion failure");
    end
  end

  task automatic do_fetch(input logic [icache_pkg::ADDR_W-1:0] addr,
                          output logic [icache_pkg::WORD_W-1:0] data);
    @(posedge clk);
    fetch_req_i  <= 1'b1;
    fetch_addr_i <= addr;
    do begin
      @(posedge clk);
    end while (!fetch_ack_o);
    data = fetch_data_o;
    fetch_req_i <= 1'b0;
    do begin
      @(posedge clk);
    end while (fetch_ack_o);
  endtask

  task automatic check_fetch(input logic [icache_pkg::ADDR_W-1:0] addr);
    logic [icache_pkg::WORD_W-1:0] data;
    bit                            exp_miss;
    int                            reqs_before;
    exp_miss    = model_access(addr);
    reqs_before = mem_reqs;
    do_fetch(addr, data);
    if (mem_reqs - reqs_before > 1) begin
      stop_with_failure($sformatf("More than one memory request for the fetch of %h", addr));
    end
    compare_miss("miss", mem_reqs != reqs_before, exp_miss);
    compare_word("fetch_data_o", data, expected_word(addr));
    if (exp_miss) begin
      compare_addr("mem_addr_o", last_mem_addr, {addr[31:4], 4'h0});
    end
  endtask

  task automatic do_flush();
    @(posedge clk);
    flush_req_i <= 1'b1;
    do begin
      @(posedge clk);
    end while (!flush_ack_o);
    flush_req_i <= 1'b0;
    do begin
      @(posedge clk);
    end while (flush_ack_o);
    for (int s = 0; s < SETS; s++) begin
      for (int w = 0; w < icache_pkg::WAYS; w++) begin
        model_valid[s][w] = 1'b0;
      end
    end
  endtask

  // Line k of set 5, with the word offset varied by k
  function automatic logic [icache_pkg::ADDR_W-1:0] same_set_addr(input int k);
    return {20'h0, 4'(k), 4'h5, 2'(k), 2'b00};
  endfunction

  task automatic test_cold_miss();
    check_fetch(32'h0000_0104);
  endtask

  task automatic test_hits();
    for (int i = 0; i < icache_pkg::LINE_WORDS; i++) begin
      check_fetch(32'h0000_0100 + 32'(4 * i));
    end
  endtask

  task automatic test_replacement();
    int order [6] = '{3, 4, 5, 6, 1, 2};
    for (int k = 1; k <= 6; k++) begin
      check_fetch(same_set_addr(k));
    end
    // Lines 1 and 2 were evicted, the rest still hit
    for (int i = 0; i < 6; i++) begin
      check_fetch(same_set_addr(order[i]));
    end
  endtask

  task automatic test_flush();
    do_flush();
    check_fetch(32'h0000_0104);
    for (int k = 1; k <= 6; k++) begin
      check_fetch(same_set_addr(k));
    end
  endtask

  task automatic test_random();
    for (int n = 0; n < NUM_RANDOM; n++) begin
      check_fetch(32'h0000_4000 + {22'h0, addr_seed[23:16], 2'b00});
      addr_seed = lcg_step(addr_seed);
    end
  endtask

  task automatic test_backpressure();
    logic [icache_pkg::WORD_W-1:0] held;
    void'(model_access(32'h0000_2468));
    @(posedge clk);
    fetch_req_i  <= 1'b1;
    fetch_addr_i <= 32'h0000_2468;
    do begin
      @(posedge clk);
    end while (!fetch_ack_o);
    held = fetch_data_o;
    compare_word("fetch_data_o", held, expected_word(32'h0000_2468));
    repeat (6) begin
      @(posedge clk);
      if (!fetch_ack_o) begin
        stop_with_failure("fetch_ack_o dropped while fetch_req_i was still high");
      end
      compare_word("fetch_data_o", fetch_data_o, held);
    end
    fetch_req_i <= 1'b0;
    @(posedge clk);
    @(posedge clk);
    if (fetch_ack_o) begin
      stop_with_failure("fetch_ack_o stayed high after fetch_req_i dropped");
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    flush_req_i  = 1'b0;
    addr_seed    = 32'h27b3;
    model_rr     = 0;
    for (int s = 0; s < SETS; s++) begin
      for (int w = 0; w < icache_pkg::WAYS; w++) begin
        model_valid[s][w] = 1'b0;
        model_tag[s][w]   = '0;
      end
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    test_cold_miss();
    test_hits();
    test_replacement();
    test_flush();
    test_random();
    test_backpressure();
    if (i_icache_top.i_icache_properties.fail_count == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("TESTBENCH FAILED");
      $fatal(1, "%0d assertion failures", i_icache_top.i_icache_properties.fail_count);
    end
  end

endmodule

`default_nettype wire

// File: dv/icache_properties.sv
// Handshake checks bound into the cache top level; only active while rst_n is high
`default_nettype none

module icache_properties (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic fetch_req_i,
  input wire logic fetch_ack_o,
  input wire logic flush_req_i,
  input wire logic flush_ack_o,
  input wire logic mem_req_o,
  input wire logic mem_ack_i
);

  int fail_count = 0;

  fetch_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(fetch_ack_o) |-> fetch_req_i)
  else begin
    fail_count++;
    $error("fetch_ack_o rose without fetch_req_i");
  end

  // Request held until the memory answers
  mem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o && !mem_ack_i |=> mem_req_o)
  else begin
    fail_count++;
    $error("mem_req_o dropped before mem_ack_i");
  end

  flush_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(flush_ack_o) |-> flush_req_i)
  else begin
    fail_count++;
    $error("flush_ack_o rose without flush_req_i");
  end

  ack_and_mem_req_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(fetch_ack_o && mem_req_o))
  else begin
    fail_count++;
    $error("fetch_ack_o and mem_req_o high together");
  end

endmodule

bind icache_top icache_properties i_icache_properties (
  .clk         (clk),
  .rst_n       (rst_n),
  .fetch_req_i (fetch_req_i),
  .fetch_ack_o (fetch_ack_o),
  .flush_req_i (flush_req_i),
  .flush_ack_o (flush_ack_o),
  .mem_req_o   (mem_req_o),
  .mem_ack_i   (mem_ack_i)
);

`default_nettype wire

// File: hdl/icache_top.sv
// Four-way instruction cache, read only; SETS must be a power of two of at least 2
`default_nettype none

module icache_top #(
  parameter int SETS = 16
) (
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  input  wire logic                              fetch_req_i,
  input  wire logic [icache_pkg::ADDR_W-1:0]     fetch_addr_i,
  output logic                                   fetch_ack_o,
  output logic      [icache_pkg::WORD_W-1:0]     fetch_data_o,
  input  wire logic                              flush_req_i,
  output logic                                   flush_ack_o,
  output logic                                   mem_req_o,
  output logic      [icache_pkg::ADDR_W-1:0]     mem_addr_o,
  input  wire logic                              mem_ack_i,
  input  wire logic [icache_pkg::LINE_W-1:0]     mem_line_i
);

  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - IDX_W;

  logic                                                    ram_rd_en;
  logic [IDX_W-1:0]                                        ram_index;
  logic [icache_pkg::WAYS-1:0]                             ram_wr_en;
  logic [TAG_W-1:0]                                        ram_tag;
  logic                                                    ram_clear;
  logic [TAG_W-1:0]                                        req_tag;
  logic [icache_pkg::WORD_SEL_W-1:0]                       word_sel;
  logic                                                    hit;
  logic [icache_pkg::WORD_W-1:0]                           hit_word;
  logic                                                    any_invalid;
  logic [icache_pkg::WAY_W-1:0]                            invalid_way;
  logic [icache_pkg::WAYS-1:0]                             way_valid;
  logic [icache_pkg::WAYS-1:0][TAG_W-1:0]                  way_tag;
  logic [icache_pkg::WAYS-1:0][icache_pkg::LINE_W-1:0]     way_line;

  icache_ctrl #(
    .SETS (SETS)
  ) i_icache_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ack_o   (fetch_ack_o),
    .fetch_data_o  (fetch_data_o),
    .flush_req_i   (flush_req_i),
    .flush_ack_o   (flush_ack_o),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_ack_i     (mem_ack_i),
    .mem_line_i    (mem_line_i),
    .ram_rd_en_o   (ram_rd_en),
    .ram_index_o   (ram_index),
    .ram_wr_en_o   (ram_wr_en),
    .ram_tag_o     (ram_tag),
    .ram_clear_o   (ram_clear),
    .req_tag_o     (req_tag),
    .word_sel_o    (word_sel),
    .hit_i         (hit),
    .hit_word_i    (hit_word),
    .any_invalid_i (any_invalid),
    .invalid_way_i (invalid_way)
  );

  icache_lookup #(
    .SETS (SETS)
  ) i_icache_lookup (
    .valid_i       (way_valid),
    .tags_i        (way_tag),
    .lines_i       (way_line),
    .tag_i         (req_tag),
    .word_sel_i    (word_sel),
    .hit_o         (hit),
    .hit_word_o    (hit_word),
    .any_invalid_o (any_invalid),
    .invalid_way_o (invalid_way)
  );

  // One tag and data RAM pair per way
  for (genvar w = 0; w < icache_pkg::WAYS; w++) begin : g_way
    icache_tag_ram #(
      .SETS (SETS)
    ) i_icache_tag_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .rd_en_i (ram_rd_en),
      .index_i (ram_index),
      .wr_en_i (ram_wr_en[w]),
      .tag_i   (ram_tag),
      .clear_i (ram_clear),
      .valid_o (way_valid[w]),
      .tag_o   (way_tag[w])
    );

    icache_data_ram #(
      .SETS (SETS)
    ) i_icache_data_ram (
      .clk     (clk),
      .rd_en_i (ram_rd_en),
      .index_i (ram_index),
      .wr_en_i (ram_wr_en[w]),
      .line_i  (mem_line_i),
      .line_o  (way_line[w])
    );
  end

endmodule

`default_nettype wire

// File: hdl/icache_ctrl.sv
// Cache FSM; fetch wins over flush in idle, and the victim pointer is shared by all sets
`default_nettype none

module icache_ctrl #(
  parameter int SETS = 16
) (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  // Fetch side
  input  wire logic                                fetch_req_i,
  input  wire logic [icache_pkg::ADDR_W-1:0]       fetch_addr_i,
  output logic                                     fetch_ack_o,
  output logic      [icache_pkg::WORD_W-1:0]       fetch_data_o,
  // Flush side
  input  wire logic                                flush_req_i,
  output logic                                     flush_ack_o,
  // Memory side
  output logic                                     mem_req_o,
  output logic      [icache_pkg::ADDR_W-1:0]       mem_addr_o,
  input  wire logic                                mem_ack_i,
  input  wire logic [icache_pkg::LINE_W-1:0]       mem_line_i,
  // RAM control
  output logic                                     ram_rd_en_o,
  output logic      [IDX_W-1:0]                    ram_index_o,
  output logic      [icache_pkg::WAYS-1:0]         ram_wr_en_o,
  output logic      [TAG_W-1:0]                    ram_tag_o,
  output logic                                     ram_clear_o,
  // Lookup
  output logic      [TAG_W-1:0]                    req_tag_o,
  output logic      [icache_pkg::WORD_SEL_W-1:0]   word_sel_o,
  input  wire logic                                hit_i,
  input  wire logic [icache_pkg::WORD_W-1:0]       hit_word_i,
  input  wire logic                                any_invalid_i,
  input  wire logic [icache_pkg::WAY_W-1:0]        invalid_way_i
);

  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - IDX_W;

  icache_pkg::icache_state_e state_q;

  logic [icache_pkg::ADDR_W-1:0]  addr_q;
  logic [IDX_W-1:0]               flush_idx_q;
  logic [icache_pkg::WAY_W-1:0]   rr_ptr_q;
  logic [icache_pkg::WAY_W-1:0]   victim_q;
  logic                           victim_full_q;
  logic                           accept_fetch;
  logic                           accept_flush;
  logic                           fill_done;
  logic [icache_pkg::WORD_W-1:0]  fill_word;

  assign accept_fetch = (state_q == icache_pkg::ST_IDLE) && fetch_req_i && !fetch_ack_o;
  assign accept_flush = (state_q == icache_pkg::ST_IDLE) && flush_req_i && !fetch_req_i
                        && !flush_ack_o;
  assign fill_done    = (state_q == icache_pkg::ST_FILL) && mem_req_o && mem_ack_i;

  // Address fields of the saved request
  assign req_tag_o  = addr_q[icache_pkg::ADDR_W-1 -: TAG_W];
  assign word_sel_o = addr_q[icache_pkg::OFFSET_W-1 -: icache_pkg::WORD_SEL_W];
  assign mem_addr_o = {addr_q[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
                       {icache_pkg::OFFSET_W{1'b0}}};
  assign fill_word  = mem_line_i[word_sel_o * icache_pkg::WORD_W +: icache_pkg::WORD_W];

  // RAM side
  assign ram_rd_en_o = accept_fetch;
  assign ram_clear_o = (state_q == icache_pkg::ST_FLUSH);
  assign ram_tag_o   = req_tag_o;

  always_comb begin
    if (state_q == icache_pkg::ST_IDLE) begin
      ram_index_o = fetch_addr_i[icache_pkg::OFFSET_W +: IDX_W];
    end else if (state_q == icache_pkg::ST_FLUSH) begin
      ram_index_o = flush_idx_q;
    end else begin
      ram_index_o = addr_q[icache_pkg::OFFSET_W +: IDX_W];
    end
  end

  always_comb begin
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      ram_wr_en_o[w] = fill_done && (victim_q == icache_pkg::WAY_W'(w));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q     <= icache_pkg::ST_IDLE;
      fetch_ack_o <= 1'b0;
      flush_ack_o <= 1'b0;
      mem_req_o   <= 1'b0;
      rr_ptr_q    <= '0;
      flush_idx_q <= '0;
    end else begin
      case (state_q)
        icache_pkg::ST_IDLE: begin
          if (accept_fetch) begin
            state_q <= icache_pkg::ST_LOOKUP;
          end else if (accept_flush) begin
            state_q     <= icache_pkg::ST_FLUSH;
            flush_idx_q <= '0;
          end
        end
        icache_pkg::ST_LOOKUP: begin
          state_q <= hit_i ? icache_pkg::ST_RESPOND : icache_pkg::ST_FILL;
        end
        icache_pkg::ST_FILL: begin
          if (fill_done) begin
            mem_req_o <= 1'b0;
            state_q   <= icache_pkg::ST_RESPOND;
            if (victim_full_q) begin
              rr_ptr_q <= rr_ptr_q + 1'b1;
            end
          end else if (!mem_req_o && !mem_ack_i) begin
            // Previous memory ack must be gone first
            mem_req_o <= 1'b1;
          end
        end
        icache_pkg::ST_RESPOND: begin
          if (!fetch_ack_o) begin
            fetch_ack_o <= 1'b1;
          end else if (!fetch_req_i) begin
            fetch_ack_o <= 1'b0;
            state_q     <= icache_pkg::ST_IDLE;
          end
        end
        icache_pkg::ST_FLUSH: begin
          flush_idx_q <= flush_idx_q + 1'b1;
          if (flush_idx_q == IDX_W'(SETS - 1)) begin
            state_q <= icache_pkg::ST_FLUSH_ACK;
          end
        end
        icache_pkg::ST_FLUSH_ACK: begin
          if (!flush_ack_o) begin
            flush_ack_o <= 1'b1;
          end else if (!flush_req_i) begin
            flush_ack_o <= 1'b0;
            state_q     <= icache_pkg::ST_IDLE;
          end
        end
        default: begin
          state_q <= icache_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // Request payload, victim choice and returned word
  always_ff @(posedge clk) begin
    if (accept_fetch) begin
      addr_q <= fetch_addr_i;
    end
    if (state_q == icache_pkg::ST_LOOKUP) begin
      fetch_data_o  <= hit_word_i;
      victim_q      <= any_invalid_i ? invalid_way_i : rr_ptr_q;
      victim_full_q <= !any_invalid_i;
    end
    if (fill_done) begin
      fetch_data_o <= fill_word;
    end
  end

endmodule

`default_nettype wire

// File: hdl/icache_lookup.sv
// Purely combinational way compare; at most one way may hold a given tag in a set
`default_nettype none

module icache_lookup #(
  parameter int SETS = 16
) (
  input  wire logic [icache_pkg::WAYS-1:0]                          valid_i,
  input  wire logic [icache_pkg::WAYS-1:0][TAG_W-1:0]               tags_i,
  input  wire logic [icache_pkg::WAYS-1:0][icache_pkg::LINE_W-1:0]  lines_i,
  input  wire logic [TAG_W-1:0]                                     tag_i,
  input  wire logic [icache_pkg::WORD_SEL_W-1:0]                    word_sel_i,
  output logic                                                      hit_o,
  output logic      [icache_pkg::WORD_W-1:0]                        hit_word_o,
  output logic                                                      any_invalid_o,
  output logic      [icache_pkg::WAY_W-1:0]                         invalid_way_o
);

  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - IDX_W;

  logic [icache_pkg::LINE_W-1:0] hit_line;

  always_comb begin
    hit_o    = 1'b0;
    hit_line = '0;
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      if (valid_i[w] && (tags_i[w] == tag_i)) begin
        hit_o    = 1'b1;
        hit_line = lines_i[w];
      end
    end
  end

  assign hit_word_o = hit_line[word_sel_i * icache_pkg::WORD_W +: icache_pkg::WORD_W];

  // Walk downwards so the lowest invalid way wins
  always_comb begin
    any_invalid_o = 1'b0;
    invalid_way_o = '0;
    for (int w = icache_pkg::WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        any_invalid_o = 1'b1;
        invalid_way_o = icache_pkg::WAY_W'(w);
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/icache_data_ram.sv
// One way of line storage with a registered read; a read and a write to one set return old data
`default_nettype none

module icache_data_ram #(
  parameter int SETS = 16
) (
  input  wire logic                             clk,
  input  wire logic                             rd_en_i,
  input  wire logic [IDX_W-1:0]                 index_i,
  input  wire logic                             wr_en_i,
  input  wire logic [icache_pkg::LINE_W-1:0]    line_i,
  output logic      [icache_pkg::LINE_W-1:0]    line_o
);

  localparam int IDX_W = $clog2(SETS);

  logic [icache_pkg::LINE_W-1:0] line_mem [SETS];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      line_mem[index_i] <= line_i;
    end
    if (rd_en_i) begin
      line_o <= line_mem[index_i];
    end
  end

endmodule

`default_nettype wire

// File: hdl/icache_tag_ram.sv
// One way of tags and valid bits; SETS must be a power of two of at least 2, clear beats write
`default_nettype none

module icache_tag_ram #(
  parameter int SETS = 16
) (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                rd_en_i,
  input  wire logic [IDX_W-1:0]    index_i,
  input  wire logic                wr_en_i,
  input  wire logic [TAG_W-1:0]    tag_i,
  input  wire logic                clear_i,
  output logic                     valid_o,
  output logic      [TAG_W-1:0]    tag_o
);

  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - IDX_W;

  logic [SETS-1:0]  valid_q;
  logic [TAG_W-1:0] tag_mem [SETS];

  // Valid bits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
      valid_o <= 1'b0;
    end else begin
      if (clear_i) begin
        valid_q[index_i] <= 1'b0;
      end else if (wr_en_i) begin
        valid_q[index_i] <= 1'b1;
      end
      if (rd_en_i) begin
        valid_o <= valid_q[index_i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      tag_mem[index_i] <= tag_i;
    end
    if (rd_en_i) begin
      tag_o <= tag_mem[index_i];
    end
  end

endmodule

`default_nettype wire

// File: hdl/icache_pkg.sv
// Shared cache geometry and FSM states; a line is four 32-bit words and the address is 32 bits
`default_nettype none

package icache_pkg;

  // Byte address and instruction word
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // Line geometry
  localparam int LINE_WORDS = 4;
  localparam int LINE_W     = LINE_WORDS * WORD_W;
  localparam int OFFSET_W   = 4;
  localparam int WORD_SEL_W = $clog2(LINE_WORDS);

  // Associativity
  localparam int WAYS  = 4;
  localparam int WAY_W = $clog2(WAYS);

  // Cache controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_FILL,
    ST_RESPOND,
    ST_FLUSH,
    ST_FLUSH_ACK
  } icache_state_e;

endpackage

`default_nettype wire
